// ==== common/engine_pkg.sv ====
// Q8.8 signed operands; every saturation clamps to the signed 16-bit range
package engine_pkg;

	typedef enum logic [2:0] {
		OP_CONV1 = 3'd1,
		OP_CONV3 = 3'd2,
		OP_CONVP = 3'd3,
		OP_MPOOL = 3'd4,
		OP_APOOL = 3'd5
	} op_t;

	localparam int WORD_W     = 16;
	localparam int ACC_W      = 40;
	localparam int FRAC_BITS  = 8;
	localparam int CONV_LANES = 4;
	localparam int LANE_W     = 3;
	localparam int FIFO_DEPTH = 32;
	localparam int COUNT_W    = 16;

	// Signed word limits, widened to the accumulator
	localparam logic signed [ACC_W-1:0] SAT_MAX = ACC_W'((1 << (WORD_W - 1)) - 1);
	localparam logic signed [ACC_W-1:0] SAT_MIN = -SAT_MAX - ACC_W'(1);

	function automatic logic [WORD_W-1:0] sat_word(input logic signed [ACC_W-1:0] value);
		logic [WORD_W-1:0] clamped;
		if (value > SAT_MAX)
			clamped = SAT_MAX[WORD_W-1:0];
		else if (value < SAT_MIN)
			clamped = SAT_MIN[WORD_W-1:0];
		else
			clamped = value[WORD_W-1:0];
		return clamped;
	endfunction

endpackage

// ==== hdl/operand_fifo.sv ====
// Pushes while full are dropped; pop_data updates one cycle after a pop on a non-empty FIFO
`timescale 1ns/1ps

module operand_fifo
	import engine_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              push,
	input  logic [WORD_W-1:0] push_data,
	input  logic              pop,
	output logic [WORD_W-1:0] pop_data,
	output logic              empty,
	output logic              full
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	logic [WORD_W-1:0] mem [FIFO_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [PTR_W:0]    count;
	logic              do_push;
	logic              do_pop;

	assign empty   = (count == '0);
	assign full    = (count == (PTR_W+1)'(FIFO_DEPTH));
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	// Storage and read register
	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
		if (do_pop)
			pop_data <= mem[rd_ptr];
	end

endmodule

// ==== hdl/cmac.sv ====
// Signed Q8.8 inputs; clear wins over acc_en and the result saturates to 16 bits
`timescale 1ns/1ps

module cmac
	import engine_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              clear,
	input  logic              acc_en,
	input  logic [WORD_W-1:0] data,
	input  logic [WORD_W-1:0] weight,
	output logic [WORD_W-1:0] result
);

	logic signed [ACC_W-1:0] acc;
	logic signed [ACC_W-1:0] product;
	logic signed [ACC_W-1:0] scaled;

	// Full-precision product, sign extended to the accumulator
	assign product = $signed(data) * $signed(weight);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			acc <= '0;
		end else if (clear) begin
			acc <= '0;
		end else if (acc_en) begin
			acc <= acc + product;
		end
	end

	// Back to Q8.8
	assign scaled = acc >>> FRAC_BITS;
	assign result = sat_word(scaled);

endmodule

// ==== hdl/pool_unit.sv ====
// Max mode keeps the largest signed word; sum mode saturates only on the output
`timescale 1ns/1ps

module pool_unit
	import engine_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              clear,
	input  logic              acc_en,
	input  logic              mode_max,
	input  logic [WORD_W-1:0] data,
	output logic [WORD_W-1:0] result
);

	logic signed [ACC_W-1:0] acc;
	logic signed [ACC_W-1:0] data_ext;
	logic                    have_word;

	assign data_ext = $signed(data);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			acc       <= '0;
			have_word <= 1'b0;
		end else if (clear) begin
			acc       <= '0;
			have_word <= 1'b0;
		end else if (acc_en) begin
			have_word <= 1'b1;
			if (mode_max) begin
				// First word taken as is
				if (!have_word || data_ext > acc)
					acc <= data_ext;
			end else begin
				acc <= acc + data_ext;
			end
		end
	end

	// A stored maximum is always in range, so one clamp serves both modes
	assign result = sat_word(acc);

endmodule

// ==== engine/engine_ctrl.sv ====
// Unknown op codes or op_num of zero finish with done only; start is ignored while busy
`timescale 1ns/1ps

module engine_ctrl
	import engine_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start,
	input  op_t                   op_type,
	input  logic [COUNT_W-1:0]    op_num,
	input  logic                  empty_d0,
	input  logic                  empty_w0,
	input  logic                  empty_d1,
	input  logic                  empty_w1,
	output logic                  rd_d0,
	output logic                  rd_w0,
	output logic                  rd_d1,
	output logic                  rd_w1,
	output logic                  clear,
	output logic [CONV_LANES-1:0] acc_en_0,
	output logic [CONV_LANES-1:0] acc_en_1,
	output logic                  pool_en,
	output logic                  pool_max,
	output logic [LANE_W-1:0]     sel,
	output logic                  result_valid,
	output logic [LANE_W-1:0]     result_lane,
	output logic                  done,
	output logic                  busy
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_CONV,
		S_POOL,
		S_WRITEBACK,
		S_FINISH
	} state_t;

	state_t                state;
	op_t                   op_r;
	logic [COUNT_W-1:0]    num_r;
	logic [LANE_W-1:0]     lane_cnt;
	logic [COUNT_W-1:0]    round_cnt;
	logic                  last_issued;
	logic                  need_p0;
	logic                  need_p1;
	logic                  conv_ok;
	logic                  conv_fire;
	logic                  pool_fire;
	logic                  last_round;
	logic                  op_known;
	logic [CONV_LANES-1:0] lane_onehot;
	logic [LANE_W-1:0]     first_lane;
	logic [LANE_W-1:0]     last_lane;

	assign need_p0 = (op_r == OP_CONV3) || (op_r == OP_CONVP);
	assign need_p1 = (op_r == OP_CONV1) || (op_r == OP_CONVP);

	// Both FIFOs of every port in use must hold a word
	assign conv_ok = !(need_p0 && (empty_d0 || empty_w0)) &&
		!(need_p1 && (empty_d1 || empty_w1));
	assign conv_fire = (state == S_CONV) && !last_issued && conv_ok;
	assign pool_fire = (state == S_POOL) && !last_issued && !empty_d0;

	assign rd_d0 = (conv_fire && need_p0) || pool_fire;
	assign rd_w0 = conv_fire && need_p0;
	assign rd_d1 = conv_fire && need_p1;
	assign rd_w1 = conv_fire && need_p1;

	assign last_round  = (round_cnt == num_r - COUNT_W'(1));
	assign lane_onehot = {{(CONV_LANES-1){1'b0}}, 1'b1} << lane_cnt;
	assign busy        = (state != S_IDLE) || done;

	always_comb begin
		case (op_type)
			OP_CONV1, OP_CONV3, OP_CONVP, OP_MPOOL, OP_APOOL: op_known = 1'b1;
			default: op_known = 1'b0;
		endcase
	end

	// Write-back span for the latched op
	always_comb begin
		first_lane = (op_r == OP_CONV1) ? LANE_W'(CONV_LANES) : '0;
		case (op_r)
			OP_CONV3: last_lane = LANE_W'(CONV_LANES - 1);
			OP_CONV1, OP_CONVP: last_lane = LANE_W'(2 * CONV_LANES - 1);
			default: last_lane = '0;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state        <= S_IDLE;
			op_r         <= OP_CONV1;
			num_r        <= '0;
			lane_cnt     <= '0;
			round_cnt    <= '0;
			last_issued  <= 1'b0;
			clear        <= 1'b0;
			acc_en_0     <= '0;
			acc_en_1     <= '0;
			pool_en      <= 1'b0;
			pool_max     <= 1'b0;
			sel          <= '0;
			result_valid <= 1'b0;
			result_lane  <= '0;
			done         <= 1'b0;
		end else begin
			clear        <= 1'b0;
			// Lane enables line up with the word leaving the FIFO
			acc_en_0     <= (conv_fire && need_p0) ? lane_onehot : '0;
			acc_en_1     <= (conv_fire && need_p1) ? lane_onehot : '0;
			pool_en      <= pool_fire;
			result_valid <= (state == S_WRITEBACK);
			result_lane  <= sel;
			done         <= (state == S_FINISH);

			if (conv_fire) begin
				if (lane_cnt == LANE_W'(CONV_LANES - 1)) begin
					lane_cnt  <= '0;
					round_cnt <= round_cnt + 1'b1;
					if (last_round)
						last_issued <= 1'b1;
				end else begin
					lane_cnt <= lane_cnt + 1'b1;
				end
			end
			if (pool_fire) begin
				round_cnt <= round_cnt + 1'b1;
				if (last_round)
					last_issued <= 1'b1;
			end

			case (state)
				S_IDLE: begin
					if (start && !busy) begin
						op_r        <= op_type;
						num_r       <= op_num;
						pool_max    <= (op_type == OP_MPOOL);
						lane_cnt    <= '0;
						round_cnt   <= '0;
						last_issued <= 1'b0;
						clear       <= 1'b1;
						if (!op_known || op_num == '0)
							state <= S_FINISH;
						else if (op_type == OP_MPOOL || op_type == OP_APOOL)
							state <= S_POOL;
						else
							state <= S_CONV;
					end
				end
				// The last enable is in flight once last_issued is set
				S_CONV, S_POOL: begin
					if (last_issued) begin
						sel   <= first_lane;
						state <= S_WRITEBACK;
					end
				end
				S_WRITEBACK: begin
					if (sel == last_lane)
						state <= S_FINISH;
					else
						sel <= sel + 1'b1;
				end
				S_FINISH: state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// ==== engine/engine.sv ====
// Bank 0 holds lanes 0 to 3 on port 0, bank 1 lanes 4 to 7 on port 1
`timescale 1ns/1ps

module engine
	import engine_pkg::*;
(
	input  logic               clk,
	input  logic               rst,
	input  logic               start,
	input  op_t                op_type,
	input  logic [COUNT_W-1:0] op_num,
	input  logic [WORD_W-1:0]  data_0,
	input  logic [WORD_W-1:0]  weight_0,
	input  logic [WORD_W-1:0]  data_1,
	input  logic [WORD_W-1:0]  weight_1,
	input  logic               empty_d0,
	input  logic               empty_w0,
	input  logic               empty_d1,
	input  logic               empty_w1,
	output logic               rd_d0,
	output logic               rd_w0,
	output logic               rd_d1,
	output logic               rd_w1,
	output logic               result_valid,
	output logic [WORD_W-1:0]  result_data,
	output logic [LANE_W-1:0]  result_lane,
	output logic               done,
	output logic               busy
);

	logic                  clear;
	logic [CONV_LANES-1:0] acc_en_0;
	logic [CONV_LANES-1:0] acc_en_1;
	logic                  pool_en;
	logic                  pool_max;
	logic [LANE_W-1:0]     sel;
	logic [WORD_W-1:0]     lane_res [2*CONV_LANES];
	logic [WORD_W-1:0]     pool_res;
	logic                  pool_mode;

	engine_ctrl u_ctrl (
		.clk(clk), .rst(rst), .start(start), .op_type(op_type), .op_num(op_num),
		.empty_d0(empty_d0), .empty_w0(empty_w0), .empty_d1(empty_d1), .empty_w1(empty_w1),
		.rd_d0(rd_d0), .rd_w0(rd_w0), .rd_d1(rd_d1), .rd_w1(rd_w1),
		.clear(clear), .acc_en_0(acc_en_0), .acc_en_1(acc_en_1),
		.pool_en(pool_en), .pool_max(pool_max), .sel(sel),
		.result_valid(result_valid), .result_lane(result_lane), .done(done), .busy(busy)
	);

	for (genvar i = 0; i < CONV_LANES; i++) begin : g_bank0
		cmac u_mac (
			.clk(clk), .rst(rst), .clear(clear), .acc_en(acc_en_0[i]),
			.data(data_0), .weight(weight_0), .result(lane_res[i])
		);
	end

	for (genvar i = 0; i < CONV_LANES; i++) begin : g_bank1
		cmac u_mac (
			.clk(clk), .rst(rst), .clear(clear), .acc_en(acc_en_1[i]),
			.data(data_1), .weight(weight_1), .result(lane_res[CONV_LANES + i])
		);
	end

	pool_unit u_pool (
		.clk(clk), .rst(rst), .clear(clear), .acc_en(pool_en),
		.mode_max(pool_max), .data(data_0), .result(pool_res)
	);

	// Lane 0 reports the pooling unit once a pooling op has fed it
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			pool_mode <= 1'b0;
		else if (clear)
			pool_mode <= 1'b0;
		else if (pool_en)
			pool_mode <= 1'b1;
	end

	// Registered with result_valid in the controller
	always_ff @(posedge clk) begin
		result_data <= pool_mode ? pool_res : lane_res[sel];
	end

endmodule

// ==== hdl/engine_top.sv ====
// Four 32-word operand FIFOs feed the engine; full pushes are lost
`timescale 1ns/1ps

module engine_top
	import engine_pkg::*;
(
	input  logic               clk,
	input  logic               rst,
	input  logic               push_d0,
	input  logic               push_w0,
	input  logic               push_d1,
	input  logic               push_w1,
	input  logic [WORD_W-1:0]  push_d0_data,
	input  logic [WORD_W-1:0]  push_w0_data,
	input  logic [WORD_W-1:0]  push_d1_data,
	input  logic [WORD_W-1:0]  push_w1_data,
	output logic               full_d0,
	output logic               full_w0,
	output logic               full_d1,
	output logic               full_w1,
	input  logic               start,
	input  op_t                op_type,
	input  logic [COUNT_W-1:0] op_num,
	output logic               result_valid,
	output logic [WORD_W-1:0]  result_data,
	output logic [LANE_W-1:0]  result_lane,
	output logic               done,
	output logic               busy
);

	logic [WORD_W-1:0] data_0, weight_0, data_1, weight_1;
	logic              empty_d0, empty_w0, empty_d1, empty_w1;
	logic              rd_d0, rd_w0, rd_d1, rd_w1;

	operand_fifo u_fifo_d0 (.clk(clk), .rst(rst), .push(push_d0), .push_data(push_d0_data),
		.pop(rd_d0), .pop_data(data_0), .empty(empty_d0), .full(full_d0));
	operand_fifo u_fifo_w0 (.clk(clk), .rst(rst), .push(push_w0), .push_data(push_w0_data),
		.pop(rd_w0), .pop_data(weight_0), .empty(empty_w0), .full(full_w0));
	operand_fifo u_fifo_d1 (.clk(clk), .rst(rst), .push(push_d1), .push_data(push_d1_data),
		.pop(rd_d1), .pop_data(data_1), .empty(empty_d1), .full(full_d1));
	operand_fifo u_fifo_w1 (.clk(clk), .rst(rst), .push(push_w1), .push_data(push_w1_data),
		.pop(rd_w1), .pop_data(weight_1), .empty(empty_w1), .full(full_w1));

	engine u_engine (
		.clk(clk), .rst(rst), .start(start), .op_type(op_type), .op_num(op_num),
		.data_0(data_0), .weight_0(weight_0), .data_1(data_1), .weight_1(weight_1),
		.empty_d0(empty_d0), .empty_w0(empty_w0), .empty_d1(empty_d1), .empty_w1(empty_w1),
		.rd_d0(rd_d0), .rd_w0(rd_w0), .rd_d1(rd_d1), .rd_w1(rd_w1),
		.result_valid(result_valid), .result_data(result_data), .result_lane(result_lane),
		.done(done), .busy(busy)
	);

endmodule

// ==== sim/engine_assertions.sv ====
// Sampled on rising clk; checks other than the reset one hold off while rst is high
`timescale 1ns/1ps

module engine_assertions (
	input logic clk,
	input logic rst,
	input logic result_valid,
	input logic done,
	input logic busy
);

	int fail_count = 0;

	// Single-cycle done
	done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
	else begin
		$error("done stayed high for more than one cycle");
		fail_count = fail_count + 1;
	end

	valid_not_done: assert property (@(posedge clk) disable iff (rst) !(result_valid && done))
	else begin
		$error("result_valid and done high together");
		fail_count = fail_count + 1;
	end

	valid_needs_busy: assert property (@(posedge clk) disable iff (rst) result_valid |-> busy)
	else begin
		$error("result_valid while busy is low");
		fail_count = fail_count + 1;
	end

	// Quiet outputs through and right after reset
	reset_quiet: assert property (@(posedge clk) rst |=> !result_valid && !done)
	else begin
		$error("result_valid or done high after reset");
		fail_count = fail_count + 1;
	end

endmodule

// ==== sim/engine_tb.sv ====
// Fixed seed directed tests; every op assumes the operand FIFOs start empty
`timescale 1ns/1ps

module engine_tb
	import engine_pkg::*;
();

	logic               clk;
	logic               rst;
	logic               push_d0, push_w0, push_d1, push_w1;
	logic [WORD_W-1:0]  push_d0_data, push_w0_data, push_d1_data, push_w1_data;
	logic               full_d0, full_w0, full_d1, full_w1;
	logic               start;
	op_t                op_type;
	logic [COUNT_W-1:0] op_num;
	logic               result_valid;
	logic [WORD_W-1:0]  result_data;
	logic [LANE_W-1:0]  result_lane;
	logic               done;
	logic               busy;

	int          seed;
	time         first_result_t;
	time         last_push_t;
	logic [15:0] dq0[$], wq0[$], dq1[$], wq1[$];
	int          exp_lane[$], got_lane[$];
	logic [15:0] exp_data[$], got_data[$];

	engine_top dut (.*);

	bind engine_top engine_assertions u_assert (
		.clk(clk), .rst(rst), .result_valid(result_valid), .done(done), .busy(busy)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
		if (got !== exp) begin
			$display("[ERROR] t=%0t %s: got %0h expected %0h", $time, msg, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic logic [15:0] sat16(input longint v);
		if (v > 32767)
			return 16'h7fff;
		if (v < -32768)
			return 16'h8000;
		return v[15:0];
	endfunction

	// Roughly -2.0 to 2.0 in Q8.8
	function automatic logic [15:0] small_q88();
		return 16'($random(seed) % 512);
	endfunction

	task automatic stop_pushes();
		@(posedge clk);
		push_d0 <= 1'b0;
		push_w0 <= 1'b0;
		push_d1 <= 1'b0;
		push_w1 <= 1'b0;
		last_push_t = $time;
	endtask

	task automatic push_conv(input int port, input int n);
		logic [15:0] d, w;
		for (int i = 0; i < n; i++) begin
			d = small_q88();
			w = small_q88();
			@(posedge clk);
			if (port == 0) begin
				push_d0      <= 1'b1;
				push_w0      <= 1'b1;
				push_d0_data <= d;
				push_w0_data <= w;
				dq0.push_back(d);
				wq0.push_back(w);
			end else begin
				push_d1      <= 1'b1;
				push_w1      <= 1'b1;
				push_d1_data <= d;
				push_w1_data <= w;
				dq1.push_back(d);
				wq1.push_back(w);
			end
		end
		stop_pushes();
	endtask

	// big selects large positive words, otherwise every other word is negative
	task automatic push_pool(input int n, input bit big);
		logic [15:0] w;
		for (int i = 0; i < n; i++) begin
			w = 16'($random(seed));
			if (big)
				w = 16'h6000 | (w & 16'h0fff);
			else if (i % 2 == 0)
				w[15] = 1'b1;
			@(posedge clk);
			push_d0      <= 1'b1;
			push_d0_data <= w;
			dq0.push_back(w);
		end
		stop_pushes();
	endtask

	task automatic pulse_start(input logic [2:0] code, input int num);
		@(posedge clk);
		start   <= 1'b1;
		op_type <= op_t'(code);
		op_num  <= COUNT_W'(num);
		@(posedge clk);
		start <= 1'b0;
	endtask

	// Dot product per lane over all rounds, rescaled and clamped
	task automatic expect_conv(input int port, input int rounds);
		longint      acc [CONV_LANES];
		logic [15:0] d, w;
		for (int l = 0; l < CONV_LANES; l++)
			acc[l] = 0;
		for (int k = 0; k < rounds * CONV_LANES; k++) begin
			d = (port == 0) ? dq0.pop_front() : dq1.pop_front();
			w = (port == 0) ? wq0.pop_front() : wq1.pop_front();
			acc[k % CONV_LANES] += longint'($signed(d)) * longint'($signed(w));
		end
		for (int l = 0; l < CONV_LANES; l++) begin
			exp_lane.push_back(port * CONV_LANES + l);
			exp_data.push_back(sat16(acc[l] >>> FRAC_BITS));
		end
	endtask

	task automatic expect_pool(input int n, input bit is_max);
		longint             acc;
		logic signed [15:0] w;
		acc = 0;
		for (int k = 0; k < n; k++) begin
			w = dq0.pop_front();
			if (!is_max)
				acc += w;
			else if (k == 0 || w > acc)
				acc = w;
		end
		exp_lane.push_back(0);
		exp_data.push_back(sat16(acc));
	endtask

	task automatic collect_results();
		int cycles;
		bit seen_done;
		cycles = 0;
		seen_done = 0;
		got_lane.delete();
		got_data.delete();
		while (!seen_done) begin
			@(negedge clk);
			if (result_valid) begin
				if (got_data.size() == 0)
					first_result_t = $time;
				got_lane.push_back(result_lane);
				got_data.push_back(result_data);
			end
			seen_done = done;
			cycles++;
			if (cycles > 400) begin
				$display("Timeout: no done pulse within 400 cycles of the start");
				$display("CHECKS FAILED");
				$fatal(1, "timeout");
			end
		end
	endtask

	task automatic compare_results();
		check_eq(got_data.size(), exp_data.size(), "number of results");
		foreach (exp_data[i]) begin
			check_eq(got_lane[i], exp_lane[i], $sformatf("lane of result %0d", i));
			check_eq(got_data[i], exp_data[i], $sformatf("data of result %0d", i));
		end
		exp_lane.delete();
		exp_data.delete();
	endtask

	task automatic run_op(input logic [2:0] code, input int num);
		pulse_start(code, num);
		collect_results();
		compare_results();
	endtask

	task automatic test_convs();
		push_conv(0, 12);
		expect_conv(0, 3);
		run_op(OP_CONV3, 3);
		push_conv(1, 8);
		expect_conv(1, 2);
		run_op(OP_CONV1, 2);
		push_conv(0, 8);
		push_conv(1, 8);
		expect_conv(0, 2);
		expect_conv(1, 2);
		run_op(OP_CONVP, 2);
	endtask

	task automatic test_pools();
		push_pool(7, 1'b0);
		expect_pool(7, 1'b1);
		run_op(OP_MPOOL, 7);
		push_pool(6, 1'b1);
		expect_pool(6, 1'b0);
		run_op(OP_APOOL, 6);
	endtask

	// Starved CONV3 with a stray start while it waits
	task automatic test_backpressure();
		push_conv(0, 5);
		pulse_start(OP_CONV3, 3);
		fork
			begin
				@(negedge clk);
				check_eq(busy, 1'b1, "busy while op stalls");
				pulse_start(OP_MPOOL, 5);
				repeat (3) @(posedge clk);
				push_conv(0, 3);
				repeat (3) @(posedge clk);
				push_conv(0, 2);
				repeat (4) @(posedge clk);
				push_conv(0, 2);
			end
			collect_results();
		join
		check_eq(first_result_t > last_push_t, 1'b1, "no result before the last push");
		expect_conv(0, 3);
		compare_results();
	endtask

	// Overfill data_0 by one word, then drain it with MPOOL
	task automatic test_full_fifo();
		push_pool(FIFO_DEPTH + 1, 1'b0);
		@(negedge clk);
		check_eq(full_d0, 1'b1, "full_d0 after overfilling");
		check_eq({full_w0, full_d1, full_w1}, 3'b000, "full flags of the unused FIFOs");
		// Extra word never enters the FIFO
		void'(dq0.pop_back());
		expect_pool(FIFO_DEPTH, 1'b1);
		run_op(OP_MPOOL, FIFO_DEPTH);
		check_eq(full_d0, 1'b0, "full_d0 after draining");
	endtask

	task automatic test_empty_ops();
		run_op(3'd7, 4);
		run_op(OP_CONV3, 0);
	endtask

	initial begin
		seed         = 32'hea62;
		rst          = 1'b1;
		push_d0      = 1'b0;
		push_w0      = 1'b0;
		push_d1      = 1'b0;
		push_w1      = 1'b0;
		push_d0_data = '0;
		push_w0_data = '0;
		push_d1_data = '0;
		push_w1_data = '0;
		start        = 1'b0;
		op_type      = OP_CONV1;
		op_num       = '0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		test_convs();
		test_pools();
		test_backpressure();
		test_full_fifo();
		test_empty_ops();
		repeat (2) @(posedge clk);
		if (dut.u_assert.fail_count != 0) begin
			$display("CHECKS FAILED");
			$fatal(1, "assertion failures");
		end else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

// ==== engine_top.f ====
common/engine_pkg.sv
hdl/operand_fifo.sv
hdl/cmac.sv
hdl/pool_unit.sv
engine/engine_ctrl.sv
engine/engine.sv
hdl/engine_top.sv
sim/engine_assertions.sv
sim/engine_tb.sv

// ==== Makefile ====
# Verilator lint and simulation of the engine testbench

VERILATOR  ?= verilator
TOP        ?= engine_tb
FILELIST   ?= engine_top.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --timing --assert -Wno-fatal
PASS_TEXT  ?= ALL CHECKS PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
